// File: Makefile
TOP := csrbus_subsystem_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module $(TOP) -o Vsim

run: build
	./obj_dir/Vsim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: rtl/csr_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "csrbus_params.svh"

module csr_bank
  import csrbus_pkg::*;
(
  input var               i_clk,
  input var               i_rst_n,
  input var               i_cmd_valid,
  output logic            o_cmd_accept,
  input var csrbus_cmd_t  i_cmd,
  output logic            o_resp_valid,
  output csrbus_resp_t    o_resp
);

  localparam int IDX_W = $clog2(`CSR_BANK_REGS);
  localparam int AW    = `CSRBUS_ADDR_WIDTH;
  localparam int LAT   = `CSR_SLOW_LATENCY;

  logic [`CSRBUS_DATA_WIDTH-1:0] regs [`CSR_BANK_REGS];
  logic                 cmd_ack;
  logic                 is_posted;
  logic                 is_mapped;
  logic                 is_slow;
  logic                 is_silent;
  csrbus_resp_t         cmd_resp;
  logic                 fast_valid;
  csrbus_resp_t         fast_resp;
  logic                 hold_valid;
  csrbus_resp_t         hold_resp;
  logic [LAT-1:0]       slow_valid;
  csrbus_resp_t         slow_resp [LAT];
  logic                 collide;

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------
  always_comb begin
    is_posted = i_cmd.kind == CSRBUS_WRITE_POSTED;
    is_mapped = i_cmd.addr < AW'(`CSR_BANK_REGS);
    is_slow   = is_mapped && (i_cmd.addr >= AW'(`CSR_BANK_REGS / 2));
    is_silent = i_cmd.addr >= AW'(`CSR_SILENT_BASE);

    cmd_resp.kind  = csrbus_resp_kind(i_cmd.kind);
    cmd_resp.id    = i_cmd.id;
    cmd_resp.error = !is_mapped;
    cmd_resp.data  = '0;
    if (is_mapped && (i_cmd.kind == CSRBUS_READ)) begin
      cmd_resp.data = regs[i_cmd.addr[IDX_W-1:0]];
    end
  end

  // Fast answer blocked by the slow lane must park in the holding register
  assign collide      = fast_valid && slow_valid[LAT-1];
  assign o_cmd_accept = !hold_valid && !collide;
  assign cmd_ack      = i_cmd_valid && o_cmd_accept;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `CSR_BANK_REGS; i++) begin
        regs[i] <= '0;
      end
    end
    else if (cmd_ack && is_mapped && (i_cmd.kind != CSRBUS_READ)) begin
      regs[i_cmd.addr[IDX_W-1:0]] <= i_cmd.data;
    end
  end

  // ----------------------------------------------------------
  // Answer lanes
  // ----------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      fast_valid <= 1'b0;
      hold_valid <= 1'b0;
      slow_valid <= '0;
    end
    else begin
      // Silent region and posted writes never answer
      fast_valid <= cmd_ack && !is_posted && !is_silent && !is_slow;
      slow_valid <= {slow_valid[LAT-2:0], cmd_ack && !is_posted && is_slow};
      if (collide) begin
        hold_valid <= 1'b1;
      end
      else if (!slow_valid[LAT-1]) begin
        hold_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    fast_resp    <= cmd_resp;
    slow_resp[0] <= cmd_resp;
    for (int i = 1; i < LAT; i++) begin
      slow_resp[i] <= slow_resp[i-1];
    end
    if (collide) begin
      hold_resp <= fast_resp;
    end
  end

  // Slow lane first, then the parked answer, then the fast lane
  assign o_resp_valid = slow_valid[LAT-1] || hold_valid || fast_valid;
  assign o_resp       = slow_valid[LAT-1] ? slow_resp[LAT-1]
                      : hold_valid        ? hold_resp
                      :                     fast_resp;

endmodule

`default_nettype wire

// File: rtl/csrbus_params.svh
`ifndef CSRBUS_PARAMS_SVH
`define CSRBUS_PARAMS_SVH

// Bus field widths
`define CSRBUS_ID_WIDTH       8
`define CSRBUS_ADDR_WIDTH     8
`define CSRBUS_DATA_WIDTH     32

// Reorder slots, must be a power of two
`define CSRBUS_SLOTS          4
`define CSRBUS_SLOT_WIDTH     $clog2(`CSRBUS_SLOTS)

// Register bank layout, lower half fast and upper half slow
`define CSR_BANK_REGS         16
`define CSR_SLOW_LATENCY      6
`define CSR_SILENT_BASE       'hf0

`define CSRBUS_ERROR_DATA     32'hdead_aaaa
`define CSRBUS_TIMEOUT_WIDTH  16

`endif

// File: rtl/csrbus_pkg.sv
`default_nettype none

`include "csrbus_params.svh"

package csrbus_pkg;

  // ----------------------------------------------------------
  // Command and response kinds
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    CSRBUS_READ         = 2'd0,
    CSRBUS_WRITE        = 2'd1,
    CSRBUS_WRITE_POSTED = 2'd2
  } csrbus_cmd_e;

  typedef enum logic {
    CSRBUS_RESP_READ  = 1'b0,
    CSRBUS_RESP_WRITE = 1'b1
  } csrbus_resp_e;

  // ----------------------------------------------------------
  // Payloads
  // ----------------------------------------------------------
  // Write data rides along with the command
  typedef struct packed {
    csrbus_cmd_e                    kind;
    logic [`CSRBUS_ID_WIDTH-1:0]    id;
    logic [`CSRBUS_ADDR_WIDTH-1:0]  addr;
    logic [`CSRBUS_DATA_WIDTH-1:0]  data;
  } csrbus_cmd_t;

  typedef struct packed {
    csrbus_resp_e                   kind;
    logic [`CSRBUS_ID_WIDTH-1:0]    id;
    logic                           error;
    logic [`CSRBUS_DATA_WIDTH-1:0]  data;
  } csrbus_resp_t;

  // Response kind that answers a given command kind
  function automatic csrbus_resp_e csrbus_resp_kind(csrbus_cmd_e kind);
    return (kind == CSRBUS_READ) ? CSRBUS_RESP_READ : CSRBUS_RESP_WRITE;
  endfunction

endpackage

`default_nettype wire

// File: rtl/csrbus_reorder.sv
`timescale 1ns/1ps
`default_nettype none

`include "csrbus_params.svh"

module csrbus_reorder
  import csrbus_pkg::*;
(
  input var                               i_clk,
  input var                               i_rst_n,
  input var [`CSRBUS_ID_WIDTH-1:0]        i_base_id,
  input var                               i_timeout_enable,
  input var [`CSRBUS_TIMEOUT_WIDTH-1:0]   i_timeout_cycle,
  input var                               i_up_cmd_valid,
  output logic                            o_up_cmd_accept,
  input var csrbus_cmd_t                  i_up_cmd,
  output logic                            o_dn_cmd_valid,
  input var                               i_dn_cmd_accept,
  output csrbus_cmd_t                     o_dn_cmd,
  input var                               i_dn_resp_valid,
  input var csrbus_resp_t                 i_dn_resp,
  output logic                            o_up_resp_valid,
  input var                               i_up_resp_accept,
  output csrbus_resp_t                    o_up_resp
);

  localparam int SW = `CSRBUS_SLOT_WIDTH;
  localparam int TW = `CSRBUS_TIMEOUT_WIDTH;

  logic [SW-1:0]            req_slot;
  logic [SW-1:0]            resp_slot;
  logic [`CSRBUS_SLOTS-1:0] slot_busy;
  logic [`CSRBUS_SLOTS-1:0] waiting;
  logic                     posted;
  logic                     pass;
  logic                     np_ack;
  logic                     resp_ack;
  logic                     timeout;
  logic [TW-1:0]            timeout_count;

  // ----------------------------------------------------------
  // Command side
  // ----------------------------------------------------------
  // Posted writes need no slot and never stall
  assign posted          = i_up_cmd.kind == CSRBUS_WRITE_POSTED;
  assign pass            = posted || !slot_busy[req_slot];
  assign o_dn_cmd_valid  = i_up_cmd_valid && pass;
  assign o_up_cmd_accept = i_dn_cmd_accept && pass;
  assign np_ack          = i_up_cmd_valid && o_up_cmd_accept && !posted;

  // Slot index travels in the low ID bits toward the bank
  always_comb begin
    o_dn_cmd    = i_up_cmd;
    o_dn_cmd.id = i_base_id | `CSRBUS_ID_WIDTH'(req_slot);
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      req_slot <= '0;
    end
    else if (np_ack) begin
      req_slot <= req_slot + SW'(1);
    end
  end

  // ----------------------------------------------------------
  // Response side
  // ----------------------------------------------------------
  assign resp_ack = o_up_resp_valid && i_up_resp_accept;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      resp_slot <= '0;
    end
    else if (resp_ack) begin
      resp_slot <= resp_slot + SW'(1);
    end
  end

  csrbus_reorder_table u_table (
    .i_clk        (i_clk                        ),
    .i_rst_n      (i_rst_n                      ),
    .i_alloc      (np_ack                       ),
    .i_alloc_slot (req_slot                     ),
    .i_alloc_id   (i_up_cmd.id                  ),
    .i_alloc_kind (csrbus_resp_kind(i_up_cmd.kind)),
    .i_fill       (i_dn_resp_valid              ),
    .i_fill_slot  (i_dn_resp.id[SW-1:0]         ),
    .i_fill_kind  (i_dn_resp.kind               ),
    .i_fill_error (i_dn_resp.error              ),
    .i_fill_data  (i_dn_resp.data               ),
    .i_timeout    (timeout                      ),
    .i_release    (resp_ack                     ),
    .i_head_slot  (resp_slot                    ),
    .o_slot_busy  (slot_busy                    ),
    .o_waiting    (waiting                      ),
    .o_head_valid (o_up_resp_valid              ),
    .o_head_kind  (o_up_resp.kind               ),
    .o_head_id    (o_up_resp.id                 ),
    .o_head_error (o_up_resp.error              ),
    .o_head_data  (o_up_resp.data               )
  );

  // ----------------------------------------------------------
  // Timeout
  // ----------------------------------------------------------
  assign timeout = i_timeout_enable && (timeout_count == i_timeout_cycle);

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      timeout_count <= '0;
    end
    else if (i_timeout_enable) begin
      if (np_ack) begin
        timeout_count <= '0;
      end
      else if (waiting != '0) begin
        timeout_count <= timeout_count + TW'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/csrbus_reorder_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "csrbus_params.svh"

module csrbus_reorder_table
  import csrbus_pkg::*;
(
  input var                               i_clk,
  input var                               i_rst_n,
  input var                               i_alloc,
  input var [`CSRBUS_SLOT_WIDTH-1:0]      i_alloc_slot,
  input var [`CSRBUS_ID_WIDTH-1:0]        i_alloc_id,
  input var csrbus_resp_e                 i_alloc_kind,
  input var                               i_fill,
  input var [`CSRBUS_SLOT_WIDTH-1:0]      i_fill_slot,
  input var csrbus_resp_e                 i_fill_kind,
  input var                               i_fill_error,
  input var [`CSRBUS_DATA_WIDTH-1:0]      i_fill_data,
  input var                               i_timeout,
  input var                               i_release,
  input var [`CSRBUS_SLOT_WIDTH-1:0]      i_head_slot,
  output logic [`CSRBUS_SLOTS-1:0]        o_slot_busy,
  output logic [`CSRBUS_SLOTS-1:0]        o_waiting,
  output logic                            o_head_valid,
  output csrbus_resp_e                    o_head_kind,
  output logic [`CSRBUS_ID_WIDTH-1:0]     o_head_id,
  output logic                            o_head_error,
  output logic [`CSRBUS_DATA_WIDTH-1:0]   o_head_data
);

  localparam int SW = `CSRBUS_SLOT_WIDTH;

  logic [`CSRBUS_SLOTS-1:0]       done;
  logic [`CSRBUS_SLOTS-1:0]       slot_error;
  csrbus_resp_e                   slot_kind [`CSRBUS_SLOTS];
  logic [`CSRBUS_ID_WIDTH-1:0]    slot_id   [`CSRBUS_SLOTS];
  logic [`CSRBUS_DATA_WIDTH-1:0]  slot_data [`CSRBUS_SLOTS];

  for (genvar i = 0; i < `CSRBUS_SLOTS; i++) begin : g_slot
    logic                           busy_q;
    logic                           done_q;
    logic                           error_q;
    csrbus_resp_e                   kind_q;
    logic [`CSRBUS_ID_WIDTH-1:0]    id_q;
    logic [`CSRBUS_DATA_WIDTH-1:0]  data_q;
    logic                           alloc_hit;
    logic                           fill_hit;
    logic                           complete;

    assign alloc_hit = i_alloc && (i_alloc_slot == SW'(i));
    assign fill_hit  = i_fill && (i_fill_slot == SW'(i));
    // Only a slot still waiting for its answer can complete
    assign complete  = o_waiting[i] && (fill_hit || i_timeout);

    always_ff @(posedge i_clk, negedge i_rst_n) begin
      if (!i_rst_n) begin
        busy_q <= 1'b0;
        done_q <= 1'b0;
      end
      else if (alloc_hit) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end
      else if (complete) begin
        done_q <= 1'b1;
      end
      else if (i_release && (i_head_slot == SW'(i))) begin
        busy_q <= 1'b0;
        done_q <= 1'b0;
      end
    end

    always_ff @(posedge i_clk) begin
      if (alloc_hit) begin
        id_q   <= i_alloc_id;
        kind_q <= i_alloc_kind;
      end
      else if (complete) begin
        if (fill_hit) begin
          kind_q <= i_fill_kind;
        end
        error_q <= (fill_hit && i_fill_error) || i_timeout;
        data_q  <= i_fill_data;
      end
    end

    assign o_slot_busy[i] = busy_q;
    assign o_waiting[i]   = busy_q && !done_q;
    assign done[i]        = done_q;
    assign slot_error[i]  = error_q;
    assign slot_kind[i]   = kind_q;
    assign slot_id[i]     = id_q;
    assign slot_data[i]   = data_q;
  end

  // ----------------------------------------------------------
  // Head read-out
  // ----------------------------------------------------------
  assign o_head_valid = done[i_head_slot];
  assign o_head_kind  = slot_kind[i_head_slot];
  assign o_head_id    = slot_id[i_head_slot];
  assign o_head_error = slot_error[i_head_slot];
  assign o_head_data  = slot_error[i_head_slot] ? `CSRBUS_DATA_WIDTH'(`CSRBUS_ERROR_DATA)
                                                : slot_data[i_head_slot];

endmodule

`default_nettype wire

// File: rtl/csrbus_slicer.sv
`timescale 1ns/1ps
`default_nettype none

module csrbus_slicer #(
  parameter type  PAYLOAD_T = logic,
  parameter bit   ENABLE    = 1'b1
)(
  input var           i_clk,
  input var           i_rst_n,
  input var           i_valid,
  output logic        o_accept,
  input var PAYLOAD_T i_payload,
  output logic        o_valid,
  input var           i_accept,
  output PAYLOAD_T    o_payload
);

  if (ENABLE) begin : g_slice
    logic     valid_q;
    PAYLOAD_T payload_q;

    // Free slot, or the held item leaves this cycle
    assign o_accept = !valid_q || i_accept;

    always_ff @(posedge i_clk, negedge i_rst_n) begin
      if (!i_rst_n) begin
        valid_q <= 1'b0;
      end
      else if (o_accept) begin
        valid_q <= i_valid;
      end
    end

    always_ff @(posedge i_clk) begin
      if (i_valid && o_accept) begin
        payload_q <= i_payload;
      end
    end

    assign o_valid   = valid_q;
    assign o_payload = payload_q;
  end
  else begin : g_bypass
    assign o_valid   = i_valid;
    assign o_accept  = i_accept;
    assign o_payload = i_payload;
  end

endmodule

`default_nettype wire

// File: rtl/csrbus_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "csrbus_params.svh"

module csrbus_subsystem
  import csrbus_pkg::*;
#(
  parameter bit UP_SLICER = 1'b1,
  parameter bit DN_SLICER = 1'b1
)(
  input var                               i_clk,
  input var                               i_rst_n,
  input var [`CSRBUS_ID_WIDTH-1:0]        i_base_id,
  input var                               i_timeout_enable,
  input var [`CSRBUS_TIMEOUT_WIDTH-1:0]   i_timeout_cycle,
  input var                               i_cmd_valid,
  output logic                            o_cmd_accept,
  input var csrbus_cmd_e                  i_cmd,
  input var [`CSRBUS_ID_WIDTH-1:0]        i_cmd_id,
  input var [`CSRBUS_ADDR_WIDTH-1:0]      i_cmd_addr,
  input var [`CSRBUS_DATA_WIDTH-1:0]      i_cmd_data,
  output logic                            o_resp_valid,
  input var                               i_resp_accept,
  output csrbus_resp_e                    o_resp,
  output logic [`CSRBUS_ID_WIDTH-1:0]     o_resp_id,
  output logic                            o_resp_error,
  output logic [`CSRBUS_DATA_WIDTH-1:0]   o_resp_data
);

  csrbus_cmd_t  req_cmd;
  csrbus_cmd_t  up_cmd;
  csrbus_cmd_t  dn_cmd;
  csrbus_cmd_t  bank_cmd;
  csrbus_resp_t up_resp;
  csrbus_resp_t req_resp;
  csrbus_resp_t bank_resp;
  csrbus_resp_t dn_resp;
  logic         up_cmd_valid;
  logic         up_cmd_accept;
  logic         up_resp_valid;
  logic         up_resp_accept;
  logic         dn_cmd_valid;
  logic         dn_cmd_accept;
  logic         bank_cmd_valid;
  logic         bank_cmd_accept;
  logic         bank_resp_valid;
  logic         dn_resp_valid;

  assign req_cmd      = '{kind: i_cmd, id: i_cmd_id, addr: i_cmd_addr, data: i_cmd_data};
  assign o_resp       = req_resp.kind;
  assign o_resp_id    = req_resp.id;
  assign o_resp_error = req_resp.error;
  assign o_resp_data  = req_resp.data;

  // ----------------------------------------------------------
  // Requester side
  // ----------------------------------------------------------
  csrbus_slicer #(.PAYLOAD_T(csrbus_cmd_t), .ENABLE(UP_SLICER)) u_up_cmd_slicer (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(i_cmd_valid), .o_accept(o_cmd_accept), .i_payload(req_cmd),
    .o_valid(up_cmd_valid), .i_accept(up_cmd_accept), .o_payload(up_cmd)
  );

  csrbus_slicer #(.PAYLOAD_T(csrbus_resp_t), .ENABLE(UP_SLICER)) u_up_resp_slicer (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(up_resp_valid), .o_accept(up_resp_accept), .i_payload(up_resp),
    .o_valid(o_resp_valid), .i_accept(i_resp_accept), .o_payload(req_resp)
  );

  csrbus_reorder u_reorder (
    .i_clk            (i_clk            ),
    .i_rst_n          (i_rst_n          ),
    .i_base_id        (i_base_id        ),
    .i_timeout_enable (i_timeout_enable ),
    .i_timeout_cycle  (i_timeout_cycle  ),
    .i_up_cmd_valid   (up_cmd_valid     ),
    .o_up_cmd_accept  (up_cmd_accept    ),
    .i_up_cmd         (up_cmd           ),
    .o_dn_cmd_valid   (dn_cmd_valid     ),
    .i_dn_cmd_accept  (dn_cmd_accept    ),
    .o_dn_cmd         (dn_cmd           ),
    .i_dn_resp_valid  (dn_resp_valid    ),
    .i_dn_resp        (dn_resp          ),
    .o_up_resp_valid  (up_resp_valid    ),
    .i_up_resp_accept (up_resp_accept   ),
    .o_up_resp        (up_resp          )
  );

  // ----------------------------------------------------------
  // Bank side
  // ----------------------------------------------------------
  csrbus_slicer #(.PAYLOAD_T(csrbus_cmd_t), .ENABLE(DN_SLICER)) u_dn_cmd_slicer (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(dn_cmd_valid), .o_accept(dn_cmd_accept), .i_payload(dn_cmd),
    .o_valid(bank_cmd_valid), .i_accept(bank_cmd_accept), .o_payload(bank_cmd)
  );

  // Controller never back-pressures bank answers
  csrbus_slicer #(.PAYLOAD_T(csrbus_resp_t), .ENABLE(DN_SLICER)) u_dn_resp_slicer (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(bank_resp_valid), .o_accept(), .i_payload(bank_resp),
    .o_valid(dn_resp_valid), .i_accept(1'b1), .o_payload(dn_resp)
  );

  csr_bank u_bank (
    .i_clk        (i_clk            ),
    .i_rst_n      (i_rst_n          ),
    .i_cmd_valid  (bank_cmd_valid   ),
    .o_cmd_accept (bank_cmd_accept  ),
    .i_cmd        (bank_cmd         ),
    .o_resp_valid (bank_resp_valid  ),
    .o_resp       (bank_resp        )
  );

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/csrbus_pkg.sv
rtl/csrbus_slicer.sv
rtl/csrbus_reorder_table.sv
rtl/csrbus_reorder.sv
rtl/csr_bank.sv
rtl/csrbus_subsystem.sv
test/csrbus_reorder_checker.sv
test/csrbus_subsystem_tb.sv

// File: test/csrbus_reorder_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "csrbus_params.svh"

module csrbus_reorder_checker
  import csrbus_pkg::*;
(
  input var logic                           i_clk,
  input var logic                           i_rst_n,
  input var logic                           o_resp_valid,
  input var logic                           i_resp_accept,
  input var csrbus_resp_e                   o_resp,
  input var logic [`CSRBUS_ID_WIDTH-1:0]    o_resp_id,
  input var logic                           o_resp_error,
  input var logic [`CSRBUS_DATA_WIDTH-1:0]  o_resp_data
);

  // Response held until the requester takes it
  a_valid_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_resp_valid && !i_resp_accept |=> o_resp_valid
  ) else $error("o_resp_valid dropped before the response was accepted");

  a_payload_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_resp_valid && !i_resp_accept |=> $stable(o_resp) && $stable(o_resp_id)
                                       && $stable(o_resp_error) && $stable(o_resp_data)
  ) else $error("Response payload changed while it waited for accept");

  a_reset_idle: assert property (
    @(posedge i_clk) !i_rst_n |-> !o_resp_valid
  ) else $error("o_resp_valid high during reset");

endmodule

bind csrbus_subsystem csrbus_reorder_checker checker_i (.*);

`default_nettype wire

// File: test/csrbus_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csrbus_params.svh"

module csrbus_subsystem_tb import csrbus_pkg::*;;

  localparam int RANDOM_CMDS   = 200;
  localparam int DIRECTED_CMDS = 17;
  localparam int CYCLE_LIMIT   = 40 * (RANDOM_CMDS + DIRECTED_CMDS);
  localparam int IDX_W         = $clog2(`CSR_BANK_REGS);

  logic                           clk;
  logic                           rst_n;
  logic                           cmd_valid;
  logic                           cmd_accept;
  csrbus_cmd_e                    cmd_kind;
  logic [`CSRBUS_ID_WIDTH-1:0]    cmd_id;
  logic [`CSRBUS_ADDR_WIDTH-1:0]  cmd_addr;
  logic [`CSRBUS_DATA_WIDTH-1:0]  cmd_data;
  logic                           resp_valid;
  logic                           resp_accept;
  csrbus_resp_e                   resp_kind;
  logic [`CSRBUS_ID_WIDTH-1:0]    resp_id;
  logic                           resp_error;
  logic [`CSRBUS_DATA_WIDTH-1:0]  resp_data;

  logic [31:0]                    lfsr;
  logic                           random_accept;
  logic [`CSRBUS_DATA_WIDTH-1:0]  model [`CSR_BANK_REGS];
  csrbus_resp_t                   expected [$];
  int                             errors;
  int                             checked;
  int                             cycles;

  // Random stream, generated before reset
  csrbus_cmd_e                    rnd_kind [RANDOM_CMDS];
  logic [`CSRBUS_ID_WIDTH-1:0]    rnd_id   [RANDOM_CMDS];
  logic [`CSRBUS_ADDR_WIDTH-1:0]  rnd_addr [RANDOM_CMDS];
  logic [`CSRBUS_DATA_WIDTH-1:0]  rnd_data [RANDOM_CMDS];

  csrbus_subsystem dut_i (
    .i_clk            (clk          ),
    .i_rst_n          (rst_n        ),
    .i_base_id        (8'h40        ),
    .i_timeout_enable (1'b1         ),
    .i_timeout_cycle  (16'd64       ),
    .i_cmd_valid      (cmd_valid    ),
    .o_cmd_accept     (cmd_accept   ),
    .i_cmd            (cmd_kind     ),
    .i_cmd_id         (cmd_id       ),
    .i_cmd_addr       (cmd_addr     ),
    .i_cmd_data       (cmd_data     ),
    .o_resp_valid     (resp_valid   ),
    .i_resp_accept    (resp_accept  ),
    .o_resp           (resp_kind    ),
    .o_resp_id        (resp_id      ),
    .o_resp_error     (resp_error   ),
    .o_resp_data      (resp_data    )
  );

  always #5 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic csrbus_resp_t expect_resp(csrbus_cmd_e kind,
                                               logic [`CSRBUS_ID_WIDTH-1:0] id,
                                               logic [`CSRBUS_ADDR_WIDTH-1:0] addr);
    csrbus_resp_t r;
    r.kind  = (kind == CSRBUS_READ) ? CSRBUS_RESP_READ : CSRBUS_RESP_WRITE;
    r.id    = id;
    r.error = addr >= `CSRBUS_ADDR_WIDTH'(`CSR_BANK_REGS);
    r.data  = '0;
    if (r.error) begin
      r.data = `CSRBUS_ERROR_DATA;
    end
    else if (kind == CSRBUS_READ) begin
      r.data = model[addr[IDX_W-1:0]];
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    errors++;
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
  endtask

  // Called 1 ns after a rising edge, returns at the same point
  task automatic send(input csrbus_cmd_e kind, input logic [7:0] id,
                      input logic [7:0] addr, input logic [31:0] data);
    logic accepted;
    cmd_valid = 1'b1;
    cmd_kind  = kind;
    cmd_id    = id;
    cmd_addr  = addr;
    cmd_data  = data;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = cmd_accept;
      if (accepted && (kind != CSRBUS_WRITE_POSTED)) begin
        expected.push_back(expect_resp(kind, id, addr));
      end
      if (accepted && (kind != CSRBUS_READ) && (addr < `CSR_BANK_REGS)) begin
        model[addr[IDX_W-1:0]] = data;
      end
      @(posedge clk);
      #1;
    end
    cmd_valid = 1'b0;
  endtask

  always @(posedge clk) begin
    logic [31:0] bits;
    #1;
    if (random_accept) begin
      take_bits(2, bits);
      resp_accept = bits[1:0] != 2'b00;
    end
    else begin
      resp_accept = 1'b1;
    end
  end

  // Compare at the falling edge, where the handshake is settled
  always @(negedge clk) begin
    csrbus_resp_t want;
    if (rst_n && resp_valid && resp_accept) begin
      assert (expected.size() > 0) else begin
        errors++;
        $display("Response with id %h at %0t was not expected", resp_id, $time);
      end
      if (expected.size() > 0) begin
        want = expected.pop_front();
        checked++;
        assert (resp_kind == want.kind) else report_mismatch("o_resp", 32'(resp_kind), 32'(want.kind));
        assert (resp_id == want.id) else report_mismatch("o_resp_id", 32'(resp_id), 32'(want.id));
        assert (resp_error == want.error)
          else report_mismatch("o_resp_error", 32'(resp_error), 32'(want.error));
        assert (resp_data == want.data) else report_mismatch("o_resp_data", resp_data, want.data);
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      errors++;
      $display("Timeout after %0d cycles, %0d responses never arrived", cycles, expected.size());
      $display("Checked %0d responses, %0d errors", checked, errors);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] bits;
    clk           = 1'b0;
    rst_n         = 1'b0;
    cmd_valid     = 1'b0;
    cmd_kind      = CSRBUS_READ;
    cmd_id        = '0;
    cmd_addr      = '0;
    cmd_data      = '0;
    resp_accept   = 1'b1;
    random_accept = 1'b0;
    errors        = 0;
    checked       = 0;
    cycles        = 0;
    lfsr          = 32'h62ac926d;
    for (int i = 0; i < `CSR_BANK_REGS; i++) begin
      model[i] = '0;
    end
    for (int i = 0; i < RANDOM_CMDS; i++) begin
      take_bits(2, bits);
      rnd_kind[i] = (bits[1:0] == 2'd3) ? CSRBUS_READ : csrbus_cmd_e'(bits[1:0]);
      take_bits(4, bits);
      rnd_addr[i] = {4'h0, bits[3:0]};
      take_bits(3, bits);
      // Roughly one in eight goes to an unmapped address
      if (bits[2:0] == 3'd0) begin
        rnd_addr[i] = rnd_addr[i] | 8'h20;
      end
      take_bits(8, bits);
      rnd_id[i] = bits[7:0];
      take_bits(32, bits);
      rnd_data[i] = bits;
    end

    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;

    // Write then read back, plus a never written register
    send(CSRBUS_WRITE, 8'h01, 8'h03, 32'h1234_5678);
    send(CSRBUS_READ,  8'h02, 8'h03, '0);
    send(CSRBUS_READ,  8'h03, 8'h05, '0);
    // Slow and fast mixed, answered out of order by the bank
    send(CSRBUS_WRITE, 8'h04, 8'h09, 32'hcafe_0009);
    send(CSRBUS_READ,  8'h05, 8'h09, '0);
    send(CSRBUS_READ,  8'h06, 8'h02, '0);
    send(CSRBUS_READ,  8'h07, 8'h0c, '0);
    send(CSRBUS_READ,  8'h08, 8'h03, '0);
    // Posted writes
    send(CSRBUS_WRITE_POSTED, 8'h09, 8'h0a, 32'h0bad_f00d);
    send(CSRBUS_WRITE_POSTED, 8'h0a, 8'h01, 32'h5555_0001);
    send(CSRBUS_READ,  8'h0b, 8'h0a, '0);
    send(CSRBUS_READ,  8'h0c, 8'h01, '0);
    // Unmapped addresses
    send(CSRBUS_READ,  8'h0d, 8'h30, '0);
    send(CSRBUS_WRITE, 8'h0e, 8'h31, 32'h1111_2222);
    // Silent region, resolved by the timeout
    send(CSRBUS_READ,  8'h0f, 8'hf4, '0);
    send(CSRBUS_READ,  8'h10, 8'h02, '0);
    send(CSRBUS_READ,  8'h11, 8'h09, '0);

    random_accept = 1'b1;
    for (int i = 0; i < RANDOM_CMDS; i++) begin
      send(rnd_kind[i], rnd_id[i], rnd_addr[i], rnd_data[i]);
    end

    while (expected.size() > 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);

    $display("Checked %0d responses, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end
    else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
